// File: src/arcade_io_pkg.sv
// Arcade I/O shared package with widths, key scan codes and the packed control types

package arcade_io_pkg;

  ////////////////////////////////////////
  // Widths and defaults
  ////////////////////////////////////////

  localparam int KEY_CODE_W      = 8;
  localparam int JOY_W           = 11;
  localparam int ASPECT_W        = 12;
  localparam int STATUS_W        = 32;
  // Stretched PLL reset length in clk_sys cycles
  localparam int PLL_RST_CYCLES  = 256;
  // Flops per reset synchroniser
  localparam int RST_SYNC_STAGES = 3;

  ////////////////////////////////////////
  // PS/2 key event and scan codes
  ////////////////////////////////////////

  // Host key event, toggles once per new event
  typedef struct packed {
    logic                  toggle;
    logic                  pressed;
    logic                  extended;  // E0 prefix seen, not used for decoding
    logic [KEY_CODE_W-1:0] code;
  } key_event_t;

  // Player 1 keys
  localparam logic [KEY_CODE_W-1:0] KEY_UP    = 8'h75;
  localparam logic [KEY_CODE_W-1:0] KEY_DOWN  = 8'h72;
  localparam logic [KEY_CODE_W-1:0] KEY_LEFT  = 8'h6b;
  localparam logic [KEY_CODE_W-1:0] KEY_RIGHT = 8'h74;
  localparam logic [KEY_CODE_W-1:0] KEY_CTRL  = 8'h14;
  localparam logic [KEY_CODE_W-1:0] KEY_ALT   = 8'h11;
  localparam logic [KEY_CODE_W-1:0] KEY_SHIFT = 8'h12;
  localparam logic [KEY_CODE_W-1:0] KEY_SPACE = 8'h29;
  localparam logic [KEY_CODE_W-1:0] KEY_1     = 8'h16;
  localparam logic [KEY_CODE_W-1:0] KEY_5     = 8'h2e;
  localparam logic [KEY_CODE_W-1:0] KEY_P     = 8'h4d;
  // Player 2 keys
  localparam logic [KEY_CODE_W-1:0] KEY_R     = 8'h2d;
  localparam logic [KEY_CODE_W-1:0] KEY_F     = 8'h2b;
  localparam logic [KEY_CODE_W-1:0] KEY_D     = 8'h23;
  localparam logic [KEY_CODE_W-1:0] KEY_G     = 8'h34;
  localparam logic [KEY_CODE_W-1:0] KEY_A     = 8'h1c;
  localparam logic [KEY_CODE_W-1:0] KEY_S     = 8'h1b;
  localparam logic [KEY_CODE_W-1:0] KEY_Q     = 8'h15;
  localparam logic [KEY_CODE_W-1:0] KEY_W     = 8'h1d;
  localparam logic [KEY_CODE_W-1:0] KEY_2     = 8'h1e;
  localparam logic [KEY_CODE_W-1:0] KEY_6     = 8'h36;

  ////////////////////////////////////////
  // Player controls and options
  ////////////////////////////////////////

  // Bit 0 right, 1 left, 2 down, 3 up, 7:4 buttons, 8 start, 9 coin, 10 pause
  typedef logic [JOY_W-1:0] joy_bits_t;

  // Same bit order as joy_bits_t
  typedef struct packed {
    logic       pause;
    logic       coin;
    logic       start;
    logic [3:0] buttons;
    logic       up;
    logic       down;
    logic       left;
    logic       right;
  } player_ctrl_t;

  typedef struct packed {
    logic [3:0] offset_x;
    logic [3:0] offset_y;
    logic       rotate;
    logic       flip;
    logic       compatibility;
    logic       service;
    // Sprite, layer 0..2, row scroll, row select, sprite fb, system fb
    logic [7:0] layer_enable;
    logic [3:0] game_index;
  } options_t;

endpackage

// File: src/keys_if.sv
// Held keyboard key levels for both players, from the key decoder to the control merger
`timescale 1ns/1ps

interface keys_if;

  // Index 0 is player 1, index 1 is player 2
  logic [1:0] up;
  logic [1:0] down;
  logic [1:0] left;
  logic [1:0] right;
  logic [1:0] button_1;
  logic [1:0] button_2;
  logic [1:0] button_3;
  logic [1:0] button_4;
  logic [1:0] start;
  logic [1:0] coin;
  // Player 2 has no pause key, bit 1 stays low
  logic [1:0] pause;

  // Held levels only, no handshake
  modport source (output up, down, left, right, button_1, button_2, button_3,
                  button_4, start, coin, pause);

  modport sink (input up, down, left, right, button_1, button_2, button_3,
                button_4, start, coin, pause);

endinterface

// File: src/reset_gen.sv
// Reset generator with lock-loss PLL reset stretcher and system and CPU reset synchronisers
`timescale 1ns/1ps

module reset_gen #(
  parameter int PLL_RST_CYCLES  = arcade_io_pkg::PLL_RST_CYCLES,
  parameter int RST_SYNC_STAGES = arcade_io_pkg::RST_SYNC_STAGES
) (
  input  logic clk_sys,
  input  logic RESET,
  input  logic pll_locked,
  input  logic cpu_reset_req,
  output logic pll_rst,
  output logic rst_sys,
  output logic rst_cpu
);

  // Counter holds cycles left after the first one
  localparam int CNT_W = (PLL_RST_CYCLES > 1) ? $clog2(PLL_RST_CYCLES) : 1;

  ////////////////////////////////////////
  // PLL reset stretcher
  ////////////////////////////////////////

  logic             lock_q;
  logic [CNT_W-1:0] rst_cnt;
  logic             lock_fall;

  // High then low on consecutive edges
  // Ignored while a stretch is running
  assign lock_fall = lock_q & ~pll_locked & ~pll_rst;

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      lock_q  <= 1'b0;
      pll_rst <= 1'b0;
      rst_cnt <= '0;
    end else begin
      lock_q <= pll_locked;
      if (lock_fall) begin
        // First cycle counts here, rest in the counter
        rst_cnt <= CNT_W'(PLL_RST_CYCLES - 1);
        pll_rst <= 1'b1;
      end else if (rst_cnt != '0) begin
        rst_cnt <= rst_cnt - 1'b1;
      end else begin
        pll_rst <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Reset synchronisers
  ////////////////////////////////////////

  // Chain 0 system, chain 1 CPU
  logic [1:0] rst_src;
  logic [1:0] rst_out;

  assign rst_src[0] = RESET | ~pll_locked;
  // Registered request adds one cycle before assertion
  assign rst_src[1] = rst_src[0] | cpu_reset_req;

  for (genvar i = 0; i < 2; i++) begin : g_sync
    logic [RST_SYNC_STAGES-1:0] chain;

    // Assert at once, release through the chain
    always_ff @(posedge clk_sys or posedge rst_src[i]) begin
      if (rst_src[i]) begin
        chain <= '1;
      end else begin
        chain <= chain << 1;
      end
    end

    assign rst_out[i] = chain[RST_SYNC_STAGES-1];
  end

  assign rst_sys = rst_out[0];
  assign rst_cpu = rst_out[1];

endmodule

// File: src/ps2_key_decoder.sv
// PS/2 key decoder turning toggle-marked key events into held key states for two players
`timescale 1ns/1ps

module ps2_key_decoder (
  input  logic                     clk_sys,
  input  logic                     RESET,
  input  arcade_io_pkg::key_event_t ps2_key,
  keys_if.source                   keys
);

  logic toggle_q;
  logic new_event;

  // Player 1 key states
  logic key_up, key_down, key_left, key_right;
  logic key_ctrl, key_alt, key_space, key_shift;
  logic key_1, key_5, key_p;
  // Player 2 key states
  logic key_r, key_f, key_d, key_g;
  logic key_a, key_s, key_q, key_w;
  logic key_2, key_6;

  // New event on any toggle change
  assign new_event = ps2_key.toggle ^ toggle_q;

  ////////////////////////////////////////
  // Held key states
  ////////////////////////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      toggle_q  <= 1'b0;
      key_up    <= 1'b0;
      key_down  <= 1'b0;
      key_left  <= 1'b0;
      key_right <= 1'b0;
      key_ctrl  <= 1'b0;
      key_alt   <= 1'b0;
      key_space <= 1'b0;
      key_shift <= 1'b0;
      key_1     <= 1'b0;
      key_5     <= 1'b0;
      key_p     <= 1'b0;
      key_r     <= 1'b0;
      key_f     <= 1'b0;
      key_d     <= 1'b0;
      key_g     <= 1'b0;
      key_a     <= 1'b0;
      key_s     <= 1'b0;
      key_q     <= 1'b0;
      key_w     <= 1'b0;
      key_2     <= 1'b0;
      key_6     <= 1'b0;
    end else begin
      toggle_q <= ps2_key.toggle;
      if (new_event) begin
        // Unknown codes fall through untouched
        unique case (ps2_key.code)
          arcade_io_pkg::KEY_UP:    key_up    <= ps2_key.pressed;
          arcade_io_pkg::KEY_DOWN:  key_down  <= ps2_key.pressed;
          arcade_io_pkg::KEY_LEFT:  key_left  <= ps2_key.pressed;
          arcade_io_pkg::KEY_RIGHT: key_right <= ps2_key.pressed;
          arcade_io_pkg::KEY_CTRL:  key_ctrl  <= ps2_key.pressed;
          arcade_io_pkg::KEY_ALT:   key_alt   <= ps2_key.pressed;
          arcade_io_pkg::KEY_SPACE: key_space <= ps2_key.pressed;
          arcade_io_pkg::KEY_SHIFT: key_shift <= ps2_key.pressed;
          arcade_io_pkg::KEY_1:     key_1     <= ps2_key.pressed;
          arcade_io_pkg::KEY_5:     key_5     <= ps2_key.pressed;
          arcade_io_pkg::KEY_P:     key_p     <= ps2_key.pressed;
          arcade_io_pkg::KEY_R:     key_r     <= ps2_key.pressed;
          arcade_io_pkg::KEY_F:     key_f     <= ps2_key.pressed;
          arcade_io_pkg::KEY_D:     key_d     <= ps2_key.pressed;
          arcade_io_pkg::KEY_G:     key_g     <= ps2_key.pressed;
          arcade_io_pkg::KEY_A:     key_a     <= ps2_key.pressed;
          arcade_io_pkg::KEY_S:     key_s     <= ps2_key.pressed;
          arcade_io_pkg::KEY_Q:     key_q     <= ps2_key.pressed;
          arcade_io_pkg::KEY_W:     key_w     <= ps2_key.pressed;
          arcade_io_pkg::KEY_2:     key_2     <= ps2_key.pressed;
          arcade_io_pkg::KEY_6:     key_6     <= ps2_key.pressed;
          default: ;
        endcase
      end
    end
  end

  // Pack by player, index 0 player 1
  assign keys.up       = {key_r, key_up};
  assign keys.down     = {key_f, key_down};
  assign keys.left     = {key_d, key_left};
  assign keys.right    = {key_g, key_right};
  assign keys.button_1 = {key_a, key_ctrl};
  assign keys.button_2 = {key_s, key_alt};
  assign keys.button_3 = {key_q, key_space};
  assign keys.button_4 = {key_w, key_shift};
  assign keys.start    = {key_2, key_1};
  assign keys.coin     = {key_6, key_5};
  // No pause key for player 2
  assign keys.pause    = {1'b0, key_p};

endmodule

// File: src/control_merge.sv
// Control merger ORing held keyboard keys with joystick bits into two player control words
`timescale 1ns/1ps

module control_merge (
  keys_if.sink                        keys,
  input  arcade_io_pkg::joy_bits_t    joystick_0,
  input  arcade_io_pkg::joy_bits_t    joystick_1,
  output arcade_io_pkg::player_ctrl_t p1_ctrl,
  output arcade_io_pkg::player_ctrl_t p2_ctrl
);

  arcade_io_pkg::joy_bits_t    joy  [2];
  arcade_io_pkg::player_ctrl_t ctrl [2];

  assign joy[0] = joystick_0;
  assign joy[1] = joystick_1;

  ////////////////////////////////////////
  // Per player merge
  ////////////////////////////////////////

  // Purely combinational, joystick has no latency
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      ctrl[p].right      = keys.right[p]    | joy[p][0];
      ctrl[p].left       = keys.left[p]     | joy[p][1];
      ctrl[p].down       = keys.down[p]     | joy[p][2];
      ctrl[p].up         = keys.up[p]       | joy[p][3];
      ctrl[p].buttons[0] = keys.button_1[p] | joy[p][4];
      ctrl[p].buttons[1] = keys.button_2[p] | joy[p][5];
      ctrl[p].buttons[2] = keys.button_3[p] | joy[p][6];
      ctrl[p].buttons[3] = keys.button_4[p] | joy[p][7];
      ctrl[p].start      = keys.start[p]    | joy[p][8];
      ctrl[p].coin       = keys.coin[p]     | joy[p][9];
      // Player 2 pause comes from the joystick alone
      ctrl[p].pause      = joy[p][10];
    end
    // Keyboard pause for player 1 only
    ctrl[0].pause = keys.pause[0] | joy[0][10];
  end

  assign p1_ctrl = ctrl[0];
  assign p2_ctrl = ctrl[1];

endmodule

// File: src/option_regs.sv
// Status register block decoding game options, aspect ratio, scanlines and CPU reset request
`timescale 1ns/1ps

module option_regs (
  input  logic                                   clk_sys,
  input  logic                                   RESET,
  input  logic [arcade_io_pkg::STATUS_W-1:0]     status,
  input  logic [1:0]                             buttons,
  input  logic                                   forced_scandoubler,
  output arcade_io_pkg::options_t                options,
  output logic [arcade_io_pkg::ASPECT_W-1:0]     video_arx,
  output logic [arcade_io_pkg::ASPECT_W-1:0]     video_ary,
  output logic [1:0]                             vga_sl,
  output logic                                   scandoubler,
  output logic                                   hq2x,
  output logic                                   cpu_reset_req
);

  localparam int AW = arcade_io_pkg::ASPECT_W;

  // Menu fields
  logic [1:0] aspect;
  logic       rotate;
  logic [2:0] fx;
  logic [2:0] sl;

  assign aspect = status[2:1];
  assign rotate = status[3];
  assign fx     = status[7:5];
  // Scanline level, zero when effects are off
  assign sl     = (fx != 3'd0) ? fx - 3'd1 : 3'd0;

  ////////////////////////////////////////
  // Registered decode
  ////////////////////////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      options       <= '0;
      video_arx     <= '0;
      video_ary     <= '0;
      vga_sl        <= 2'd0;
      scandoubler   <= 1'b0;
      hq2x          <= 1'b0;
      cpu_reset_req <= 1'b0;
    end else begin
      options.offset_x      <= status[27:24];
      options.offset_y      <= status[31:28];
      options.rotate        <= rotate;
      options.flip          <= status[4];
      options.compatibility <= status[8];
      options.service       <= status[9];
      // Menu bits are disables
      options.layer_enable  <= ~status[17:10];
      options.game_index    <= status[21:18];

      // Original 4:3, swapped when rotated; else fullscreen or custom ratios
      if (aspect == 2'd0) begin
        video_arx <= rotate ? AW'(3) : AW'(4);
        video_ary <= rotate ? AW'(4) : AW'(3);
      end else begin
        video_arx <= AW'(aspect) - AW'(1);
        video_ary <= '0;
      end

      vga_sl      <= sl[1:0];
      scandoubler <= (fx != 3'd0) | forced_scandoubler;
      hq2x        <= (fx == 3'd1);

      // Menu reset or user button
      cpu_reset_req <= status[0] | buttons[1];
    end
  end

endmodule

// File: src/arcade_io.sv
// Arcade I/O top level with resets, keyboard and joystick controls and option decoding
`timescale 1ns/1ps

module arcade_io #(
  parameter int PLL_RST_CYCLES  = arcade_io_pkg::PLL_RST_CYCLES,
  parameter int RST_SYNC_STAGES = arcade_io_pkg::RST_SYNC_STAGES
) (
  input  logic                               clk_sys,
  input  logic                               RESET,
  input  logic                               pll_locked,
  output logic                               pll_rst,
  output logic                               rst_sys,
  output logic                               rst_cpu,
  input  arcade_io_pkg::key_event_t          ps2_key,
  input  arcade_io_pkg::joy_bits_t           joystick_0,
  input  arcade_io_pkg::joy_bits_t           joystick_1,
  input  logic [arcade_io_pkg::STATUS_W-1:0] status,
  input  logic [1:0]                         buttons,
  input  logic                               forced_scandoubler,
  output arcade_io_pkg::player_ctrl_t        p1_ctrl,
  output arcade_io_pkg::player_ctrl_t        p2_ctrl,
  output arcade_io_pkg::options_t            options,
  output logic [arcade_io_pkg::ASPECT_W-1:0] video_arx,
  output logic [arcade_io_pkg::ASPECT_W-1:0] video_ary,
  output logic [1:0]                         vga_sl,
  output logic                               scandoubler,
  output logic                               hq2x
);

  logic   cpu_reset_req;
  keys_if keys ();

  ////////////////////////////////////////
  // Clock and reset
  ////////////////////////////////////////

  reset_gen #(
    .PLL_RST_CYCLES  (PLL_RST_CYCLES),
    .RST_SYNC_STAGES (RST_SYNC_STAGES)
  ) u_reset_gen (
    .clk_sys       (clk_sys),
    .RESET         (RESET),
    .pll_locked    (pll_locked),
    .cpu_reset_req (cpu_reset_req),
    .pll_rst       (pll_rst),
    .rst_sys       (rst_sys),
    .rst_cpu       (rst_cpu)
  );

  // Options, video flags and CPU reset request
  option_regs u_option_regs (
    .clk_sys            (clk_sys),
    .RESET              (RESET),
    .status             (status),
    .buttons            (buttons),
    .forced_scandoubler (forced_scandoubler),
    .options            (options),
    .video_arx          (video_arx),
    .video_ary          (video_ary),
    .vga_sl             (vga_sl),
    .scandoubler        (scandoubler),
    .hq2x               (hq2x),
    .cpu_reset_req      (cpu_reset_req)
  );

  ////////////////////////////////////////
  // Controls
  ////////////////////////////////////////

  ps2_key_decoder u_ps2_key_decoder (
    .clk_sys (clk_sys),
    .RESET   (RESET),
    .ps2_key (ps2_key),
    .keys    (keys.source)
  );

  control_merge u_control_merge (
    .keys       (keys.sink),
    .joystick_0 (joystick_0),
    .joystick_1 (joystick_1),
    .p1_ctrl    (p1_ctrl),
    .p2_ctrl    (p2_ctrl)
  );

endmodule

// File: test/arcade_io_asserts.sv
// Reset generator checks on reset ordering and lock-loss PLL reset stretching
`timescale 1ns/1ps

module reset_gen_asserts (
  input logic clk_sys,
  input logic RESET,
  input logic pll_locked,
  input logic pll_rst,
  input logic rst_sys,
  input logic rst_cpu
);

  // Failure tally, read by the testbench
  int fail_count = 0;

  // CPU domain is a superset of the system domain
  a_cpu_covers_sys: assert property (@(posedge clk_sys) rst_sys |-> rst_cpu)
    else begin
      fail_count++;
      $error("rst_cpu is low while rst_sys is high");
    end

  // Lock sampled high then low one edge before the rise
  a_pll_rst_rise: assert property (@(posedge clk_sys) disable iff (RESET)
    $rose(pll_rst) |-> ($past(pll_locked, 2) && !$past(pll_locked)))
    else begin
      fail_count++;
      $error("pll_rst rose without a sampled lock fall");
    end

  // Board reset clears the stretcher
  a_pll_rst_in_reset: assert property (@(posedge clk_sys) RESET |-> !pll_rst)
    else begin
      fail_count++;
      $error("pll_rst is high during board reset");
    end

endmodule

bind reset_gen reset_gen_asserts u_reset_gen_asserts (
  .clk_sys    (clk_sys),
  .RESET      (RESET),
  .pll_locked (pll_locked),
  .pll_rst    (pll_rst),
  .rst_sys    (rst_sys),
  .rst_cpu    (rst_cpu)
);

// File: test/tb_arcade_io.sv
// Testbench for the arcade I/O block with directed reset, keyboard, joystick and option tests
`timescale 1ns/1ps

module tb_arcade_io;

  localparam int PLL_CYCLES      = arcade_io_pkg::PLL_RST_CYCLES;
  localparam int STAGES          = arcade_io_pkg::RST_SYNC_STAGES;
  localparam int AW              = arcade_io_pkg::ASPECT_W;
  localparam int KW              = arcade_io_pkg::KEY_CODE_W;
  localparam int RESET_CYCLES    = 10;
  localparam int LOCK_LOW_CYCLES = 4;
  // Tests need about 500 cycles, wide margin
  localparam int TIMEOUT_CYCLES  = 4000;
  localparam int NUM_KEYS        = 21;

  // Key map, code then player then control bit
  localparam logic [KW-1:0] MAP_CODE [NUM_KEYS] = '{
    arcade_io_pkg::KEY_UP, arcade_io_pkg::KEY_DOWN, arcade_io_pkg::KEY_LEFT,
    arcade_io_pkg::KEY_RIGHT, arcade_io_pkg::KEY_CTRL, arcade_io_pkg::KEY_ALT,
    arcade_io_pkg::KEY_SPACE, arcade_io_pkg::KEY_SHIFT, arcade_io_pkg::KEY_1,
    arcade_io_pkg::KEY_5, arcade_io_pkg::KEY_P,
    arcade_io_pkg::KEY_R, arcade_io_pkg::KEY_F, arcade_io_pkg::KEY_D,
    arcade_io_pkg::KEY_G, arcade_io_pkg::KEY_A, arcade_io_pkg::KEY_S,
    arcade_io_pkg::KEY_Q, arcade_io_pkg::KEY_W, arcade_io_pkg::KEY_2,
    arcade_io_pkg::KEY_6
  };
  localparam int MAP_PLAYER [NUM_KEYS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
                                           1, 1, 1, 1, 1, 1, 1, 1, 1, 1};
  localparam int MAP_BIT [NUM_KEYS] = '{3, 2, 1, 0, 4, 5, 6, 7, 8, 9, 10,
                                        3, 2, 1, 0, 4, 5, 6, 7, 8, 9};

  logic                               clk_sys;
  logic                               RESET;
  logic                               pll_locked;
  logic                               pll_rst;
  logic                               rst_sys;
  logic                               rst_cpu;
  arcade_io_pkg::key_event_t          ps2_key;
  arcade_io_pkg::joy_bits_t           joystick_0;
  arcade_io_pkg::joy_bits_t           joystick_1;
  logic [arcade_io_pkg::STATUS_W-1:0] status;
  logic [1:0]                         buttons;
  logic                               forced_scandoubler;
  arcade_io_pkg::player_ctrl_t        p1_ctrl;
  arcade_io_pkg::player_ctrl_t        p2_ctrl;
  arcade_io_pkg::options_t            options;
  logic [AW-1:0]                      video_arx;
  logic [AW-1:0]                      video_ary;
  logic [1:0]                         vga_sl;
  logic                               scandoubler;
  logic                               hq2x;

  logic        key_toggle;
  logic [31:0] lfsr_state = 32'h700e;
  int          cycle_count = 0;

  arcade_io #(
    .PLL_RST_CYCLES  (PLL_CYCLES),
    .RST_SYNC_STAGES (STAGES)
  ) u_arcade_io (.*);

  always #10 clk_sys = ~clk_sys;

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Drive one key event, return once the decoder has taken it
  task automatic send_key_event(input logic [KW-1:0] code, input logic pressed,
                                input logic new_toggle);
    arcade_io_pkg::key_event_t ev;
    @(posedge clk_sys);
    if (new_toggle) begin
      key_toggle = ~key_toggle;
    end
    ev.toggle   = key_toggle;
    ev.pressed  = pressed;
    ev.extended = 1'b0;
    ev.code     = code;
    ps2_key <= ev;
    @(posedge clk_sys);
    @(negedge clk_sys);
  endtask

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("TEST FAIL");
    $fatal(1, "run stopped");
  endtask

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_ctrl(input string name, input arcade_io_pkg::player_ctrl_t got,
                            input arcade_io_pkg::player_ctrl_t exp);
    if (got !== exp) begin
      stop_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_options(input arcade_io_pkg::options_t got,
                               input arcade_io_pkg::options_t exp);
    if (got !== exp) begin
      stop_run($sformatf("error at %0t ns: options is %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic check_aspect(input string name, input logic [AW-1:0] got,
                              input logic [AW-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_sl(input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("error at %0t ns: vga_sl is %0d, expected %0d", $time, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_reset();
    repeat (RESET_CYCLES) @(posedge clk_sys);
    @(negedge clk_sys);
    check_bit("pll_rst", pll_rst, 1'b0);
    check_bit("rst_sys", rst_sys, 1'b1);
    check_bit("rst_cpu", rst_cpu, 1'b1);
    check_options(options, '0);
    check_ctrl("p1_ctrl", p1_ctrl, '0);
    check_ctrl("p2_ctrl", p2_ctrl, '0);
    @(posedge clk_sys);
    RESET <= 1'b0;
    // Both chains release after STAGES edges
    for (int c = 1; c <= STAGES; c++) begin
      @(posedge clk_sys);
      @(negedge clk_sys);
      check_bit("rst_sys", rst_sys, c < STAGES);
      check_bit("rst_cpu", rst_cpu, c < STAGES);
      check_bit("pll_rst", pll_rst, 1'b0);
    end
  endtask

  task automatic test_lock_loss();
    @(posedge clk_sys);
    pll_locked <= 1'b0;
    @(negedge clk_sys);
    // System reset asserts at once, stretcher waits an edge
    check_bit("pll_rst", pll_rst, 1'b0);
    check_bit("rst_sys", rst_sys, 1'b1);
    for (int c = 1; c <= PLL_CYCLES + 2; c++) begin
      @(posedge clk_sys);
      if (c == LOCK_LOW_CYCLES) begin
        pll_locked <= 1'b1;
      end
      @(negedge clk_sys);
      check_bit("pll_rst", pll_rst, c <= PLL_CYCLES);
      check_bit("rst_sys", rst_sys, c < LOCK_LOW_CYCLES + STAGES);
      check_bit("rst_cpu", rst_cpu, c < LOCK_LOW_CYCLES + STAGES);
    end
  endtask

  // Request held for two edges, one register stage ahead of the chain
  task automatic cpu_request_case(input logic [31:0] st, input logic [1:0] bt);
    @(posedge clk_sys);
    status  <= st;
    buttons <= bt;
    @(negedge clk_sys);
    check_bit("rst_cpu", rst_cpu, 1'b0);
    for (int c = 1; c <= STAGES + 3; c++) begin
      @(posedge clk_sys);
      if (c == 2) begin
        status  <= '0;
        buttons <= '0;
      end
      @(negedge clk_sys);
      check_bit("rst_cpu", rst_cpu, c < STAGES + 3);
      check_bit("rst_sys", rst_sys, 1'b0);
    end
  endtask

  task automatic test_cpu_request();
    cpu_request_case(32'h0000_0001, 2'b00);
    cpu_request_case(32'h0000_0000, 2'b10);
  endtask

  task automatic test_keyboard();
    logic [arcade_io_pkg::JOY_W-1:0] exp_v [2];
    for (int i = 0; i < NUM_KEYS; i++) begin
      send_key_event(MAP_CODE[i], 1'b1, 1'b1);
      exp_v[0] = '0;
      exp_v[1] = '0;
      exp_v[MAP_PLAYER[i]][MAP_BIT[i]] = 1'b1;
      check_ctrl("p1_ctrl", p1_ctrl, arcade_io_pkg::player_ctrl_t'(exp_v[0]));
      check_ctrl("p2_ctrl", p2_ctrl, arcade_io_pkg::player_ctrl_t'(exp_v[1]));
      send_key_event(MAP_CODE[i], 1'b0, 1'b1);
      check_ctrl("p1_ctrl", p1_ctrl, '0);
      check_ctrl("p2_ctrl", p2_ctrl, '0);
    end
    // Enter key is not mapped
    send_key_event(8'h5a, 1'b1, 1'b1);
    check_ctrl("p1_ctrl", p1_ctrl, '0);
    check_ctrl("p2_ctrl", p2_ctrl, '0);
    // Up held, then new code and flag without a toggle
    send_key_event(arcade_io_pkg::KEY_UP, 1'b1, 1'b1);
    check_ctrl("p1_ctrl", p1_ctrl, arcade_io_pkg::player_ctrl_t'(11'h008));
    send_key_event(arcade_io_pkg::KEY_DOWN, 1'b1, 1'b0);
    check_ctrl("p1_ctrl", p1_ctrl, arcade_io_pkg::player_ctrl_t'(11'h008));
    send_key_event(arcade_io_pkg::KEY_UP, 1'b0, 1'b0);
    check_ctrl("p1_ctrl", p1_ctrl, arcade_io_pkg::player_ctrl_t'(11'h008));
    send_key_event(arcade_io_pkg::KEY_UP, 1'b0, 1'b1);
    check_ctrl("p1_ctrl", p1_ctrl, '0);
  endtask

  task automatic test_joystick();
    arcade_io_pkg::joy_bits_t j0;
    arcade_io_pkg::joy_bits_t j1;
    for (int pass = 0; pass < 2; pass++) begin
      // Second pass holds ctrl for player 1 and W for player 2
      if (pass == 1) begin
        send_key_event(arcade_io_pkg::KEY_CTRL, 1'b1, 1'b1);
        send_key_event(arcade_io_pkg::KEY_W, 1'b1, 1'b1);
      end
      for (int i = 0; i < 8; i++) begin
        j0 = arcade_io_pkg::joy_bits_t'(rand_bits(arcade_io_pkg::JOY_W));
        j1 = arcade_io_pkg::joy_bits_t'(rand_bits(arcade_io_pkg::JOY_W));
        @(posedge clk_sys);
        joystick_0 <= j0;
        joystick_1 <= j1;
        @(negedge clk_sys);
        if (pass == 1) begin
          j0 = j0 | 11'h010;
          j1 = j1 | 11'h080;
        end
        check_ctrl("p1_ctrl", p1_ctrl, arcade_io_pkg::player_ctrl_t'(j0));
        check_ctrl("p2_ctrl", p2_ctrl, arcade_io_pkg::player_ctrl_t'(j1));
      end
    end
    send_key_event(arcade_io_pkg::KEY_CTRL, 1'b0, 1'b1);
    send_key_event(arcade_io_pkg::KEY_W, 1'b0, 1'b1);
    @(posedge clk_sys);
    joystick_0 <= '0;
    joystick_1 <= '0;
  endtask

  task automatic test_options();
    logic [31:0]             st;
    logic                    fs;
    logic [1:0]              ar;
    logic [2:0]              fx;
    logic [2:0]              fx_m1;
    arcade_io_pkg::options_t exp_o;
    logic [AW-1:0]           exp_x;
    logic [AW-1:0]           exp_y;
    for (int i = 0; i < 20; i++) begin
      st = rand_bits(32);
      fs = lfsr_bit();
      @(posedge clk_sys);
      status             <= st;
      forced_scandoubler <= fs;
      @(posedge clk_sys);
      @(negedge clk_sys);
      exp_o.offset_x      = st[27:24];
      exp_o.offset_y      = st[31:28];
      exp_o.rotate        = st[3];
      exp_o.flip          = st[4];
      exp_o.compatibility = st[8];
      exp_o.service       = st[9];
      exp_o.layer_enable  = ~st[17:10];
      exp_o.game_index    = st[21:18];
      check_options(options, exp_o);
      // Aspect 0 is 4:3, turned on its side when rotated
      ar = st[2:1];
      if (ar == 2'd0) begin
        exp_x = st[3] ? AW'(3) : AW'(4);
        exp_y = st[3] ? AW'(4) : AW'(3);
      end else begin
        exp_x = AW'(ar) - AW'(1);
        exp_y = '0;
      end
      check_aspect("video_arx", video_arx, exp_x);
      check_aspect("video_ary", video_ary, exp_y);
      fx    = st[7:5];
      fx_m1 = fx - 3'd1;
      check_sl(vga_sl, (fx == 3'd0) ? 2'd0 : fx_m1[1:0]);
      check_bit("scandoubler", scandoubler, (fx != 3'd0) || fs);
      check_bit("hq2x", hq2x, fx == 3'd1);
    end
    @(posedge clk_sys);
    status             <= '0;
    forced_scandoubler <= 1'b0;
  endtask

  ////////////////////////////////////////
  // Timeout and assertion watch
  ////////////////////////////////////////

  always @(posedge clk_sys) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_run("timeout: the tests did not finish in the allowed number of cycles");
    end
  end

  always @(negedge clk_sys) begin
    if (u_arcade_io.u_reset_gen.u_reset_gen_asserts.fail_count != 0) begin
      stop_run("a reset generator assertion failed");
    end
  end

  initial begin
    clk_sys            = 1'b0;
    RESET              = 1'b1;
    pll_locked         = 1'b1;
    ps2_key            = '0;
    joystick_0         = '0;
    joystick_1         = '0;
    status             = '0;
    buttons            = '0;
    forced_scandoubler = 1'b0;
    key_toggle         = 1'b0;

    test_reset();
    test_lock_loss();
    test_cpu_request();
    test_keyboard();
    test_joystick();
    test_options();

    repeat (2) @(posedge clk_sys);
    if (u_arcade_io.u_reset_gen.u_reset_gen_asserts.fail_count == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      stop_run("reset generator assertions failed during the run");
    end
  end

endmodule

// File: list.f
src/arcade_io_pkg.sv
src/keys_if.sv
src/reset_gen.sv
src/ps2_key_decoder.sv
src/control_merge.sv
src/option_regs.sv
src/arcade_io.sv
test/arcade_io_asserts.sv
test/tb_arcade_io.sv

// File: Makefile
TOP := tb_arcade_io

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f --Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
